// ==== compile.f ====
+incdir+src
src/fu_pkg.sv
src/reg_pkg.sv
src/gpr_regfile.sv
src/issue_hazard.sv
src/operand_mux.sv
src/ex_dispatch_reg.sv
src/issue_stage.sv
sim/issue_checker.sv
sim/tb_issue_stage.sv

// ==== Makefile ====
TOOL       := verilator
FLAGS      := --binary --timing --timescale 1ns/1ps -j 0
LINT_FLAGS := --lint-only --timing --timescale 1ns/1ps
TOP        := tb_issue_stage
FILELIST   := compile.f
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := ** PASS **

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF -- '$(PASS_MSG)' $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== sim/tb_issue_stage.sv ====
`default_nettype none

`include "issue_settings.svh"

module tb_issue_stage
  import fu_pkg::*;
  import reg_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int SEED           = 83779;
  localparam int RESET_CYCLES   = 16;
  localparam int NR_TESTS       = 6;
  localparam int ENTRIES        = 40;
  localparam int TIMEOUT_CYCLES = 4 * NR_TESTS * ENTRIES + RESET_CYCLES;

  logic                        clk_i, rst_ni, flush_i, stall_i;
  logic                        issue_valid_i;
  fu_t                         issue_fu_i, fu_o;
  fu_op_t                      issue_op_i, op_o;
  reg_addr_t                   issue_rs1_i, issue_rs2_i, issue_rd_i;
  xlen_t                       issue_imm_i, issue_pc_i;
  trans_id_t                   issue_trans_id_i, trans_id_o;
  logic                        issue_use_imm_i, issue_use_pc_i, issue_use_zimm_i;
  logic                        issue_is_compressed_i, issue_ex_valid_i;
  logic                        issue_ack_o, stall_issue_o;
  xlen_t                       rs1_fwd_i, rs2_fwd_i;
  logic                        rs1_fwd_valid_i, rs2_fwd_valid_i;
  clobber_table_t              rd_clobber_i;
  commit_addr_t                commit_waddr_i;
  commit_data_t                commit_wdata_i;
  logic [`ISSUE_NR_COMMIT-1:0] commit_we_i;
  logic                        flu_ready_i, lsu_ready_i;
  xlen_t                       operand_a_o, operand_b_o, imm_o, pc_o;
  logic                        is_compressed_o;
  logic                        alu_valid_o, branch_valid_o, lsu_valid_o;
  logic                        mult_valid_o, csr_valid_o;
  int                          err_count_o, check_count_o;
  int                          cycles = 0;
  // rd of the entry on the bus, needed before the NBA lands
  reg_addr_t                   cur_rd;

  issue_stage issue_stage_inst (.*);

  issue_checker issue_checker_inst (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // hard stop, every entry is accepted within three cycles
  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: run still busy after %0d cycles", cycles);
      $display("** FAIL **");
      $finish;
    end
  end

  function automatic string test_name(input int t);
    case (t)
      1:       return "commit then read";
      2:       return "forwarding and RAW stall";
      3:       return "write after write";
      4:       return "pc, zimm and imm select";
      5:       return "back-pressure and multiply";
      default: return "exception, none and flush";
    endcase
  endfunction

  function automatic fu_t pick_fu(input int t);
    if (t == 5 && $urandom_range(2, 0) == 0) begin
      return MULT;
    end
    if (t == 6) begin
      return fu_t'(3'($urandom_range(6, 0)));
    end
    return fu_t'(3'($urandom_range(6, 1)));
  endfunction

  // ----------------------------------------
  // stimulus
  // ----------------------------------------
  task automatic new_entry(input int t);
    cur_rd = 5'($urandom);
    issue_valid_i         <= 1'b1;
    issue_fu_i            <= pick_fu(t);
    issue_op_i            <= fu_op_t'(4'($urandom));
    issue_rs1_i           <= 5'($urandom);
    issue_rs2_i           <= 5'($urandom);
    issue_rd_i            <= cur_rd;
    issue_imm_i           <= $urandom;
    issue_pc_i            <= $urandom;
    issue_trans_id_i      <= 3'($urandom);
    issue_use_imm_i       <= (t == 4) && 1'($urandom);
    issue_use_pc_i        <= (t == 4) && 1'($urandom);
    issue_use_zimm_i      <= (t == 2 || t == 4) && ($urandom_range(2, 0) == 0);
    issue_is_compressed_i <= 1'($urandom);
    issue_ex_valid_i      <= (t == 6) && ($urandom_range(3, 0) == 0);
  endtask

  // scoreboard, commit and unit state, clean clears every hazard
  task automatic drive_state(input int t, input bit clean);
    clobber_table_t              clob;
    commit_addr_t                waddr;
    commit_data_t                wdata;
    logic [`ISSUE_NR_COMMIT-1:0] we;
    int                          port;
    for (int i = 0; i < `ISSUE_NR_REGS; i++) begin
      clob[i] = NONE;
      if (!clean && (t == 2 || t == 4) && $urandom_range(3, 0) == 0) begin
        clob[i] = fu_t'(3'($urandom_range(6, 1)));
      end
    end
    if (!clean && t == 3 && $urandom_range(1, 0) == 1) begin
      clob[cur_rd] = fu_t'(3'($urandom_range(6, 1)));
    end
    for (int p = 0; p < `ISSUE_NR_COMMIT; p++) begin
      we[p]    = 1'($urandom);
      waddr[p] = 5'($urandom);
      wdata[p] = $urandom;
    end
    // release of the pending destination by a commit
    if (t == 3 && $urandom_range(1, 0) == 1) begin
      port        = $urandom_range(`ISSUE_NR_COMMIT - 1, 0);
      we[port]    = 1'b1;
      waddr[port] = cur_rd;
    end
    rd_clobber_i    <= clob;
    commit_we_i     <= we;
    commit_waddr_i  <= waddr;
    commit_wdata_i  <= wdata;
    rs1_fwd_i       <= $urandom;
    rs2_fwd_i       <= $urandom;
    rs1_fwd_valid_i <= (t == 2 || t == 4) && 1'($urandom);
    rs2_fwd_valid_i <= (t == 2 || t == 4) && 1'($urandom);
    stall_i         <= !clean && t == 5 && ($urandom_range(7, 0) == 0);
    flu_ready_i     <= clean || t != 5 || ($urandom_range(2, 0) != 0);
    lsu_ready_i     <= clean || t != 5 || ($urandom_range(2, 0) != 0);
    flush_i         <= (t == 6) && ($urandom_range(3, 0) == 0);
  endtask

  // hold the entry until the DUT takes it
  task automatic run_entry(input int t);
    int   waited;
    logic accepted;
    waited   = 0;
    accepted = 1'b0;
    @(posedge clk_i);
    new_entry(t);
    drive_state(t, 1'b0);
    while (!accepted) begin
      @(negedge clk_i);
      accepted = issue_ack_o;
      if (!accepted) begin
        waited++;
        @(posedge clk_i);
        drive_state(t, waited >= 2);
      end
    end
  endtask

  // ----------------------------------------
  // test sequence
  // ----------------------------------------
  initial begin
    int errs_before;
    int errs;
    int tests_failed;
    tests_failed = 0;
    void'($urandom(SEED));
    rst_ni         <= 1'b0;
    flush_i        <= 1'b0;
    stall_i        <= 1'b0;
    issue_valid_i  <= 1'b0;
    cur_rd         = '0;
    new_entry(1);
    issue_valid_i  <= 1'b0;
    drive_state(1, 1'b1);
    commit_we_i    <= '0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    rst_ni <= 1'b1;

    for (int t = 1; t <= NR_TESTS; t++) begin
      errs_before = err_count_o;
      for (int e = 0; e < ENTRIES; e++) begin
        run_entry(t);
      end
      // let the last entry reach the ID/EX register and get checked
      @(posedge clk_i);
      issue_valid_i <= 1'b0;
      @(posedge clk_i);
      errs = err_count_o - errs_before;
      if (errs != 0) begin
        tests_failed++;
      end
      $display("test %0d (%s): %0d entries, %0d mismatches", t, test_name(t), ENTRIES, errs);
    end

    $display("tests %0d, failing tests %0d, checks %0d, mismatches %0d",
             NR_TESTS, tests_failed, check_count_o, err_count_o);
    if (tests_failed == 0 && err_count_o == 0 && check_count_o > 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim/issue_checker.sv ====
`default_nettype none

`include "issue_settings.svh"

module issue_checker
  import fu_pkg::*;
  import reg_pkg::*;
(
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        flush_i,
  input  logic                        stall_i,
  // entry as seen by the DUT
  input  logic                        issue_valid_i,
  input  fu_t                         issue_fu_i,
  input  fu_op_t                      issue_op_i,
  input  reg_addr_t                   issue_rs1_i,
  input  reg_addr_t                   issue_rs2_i,
  input  reg_addr_t                   issue_rd_i,
  input  xlen_t                       issue_imm_i,
  input  xlen_t                       issue_pc_i,
  input  trans_id_t                   issue_trans_id_i,
  input  logic                        issue_use_imm_i, issue_use_pc_i, issue_use_zimm_i,
  input  logic                        issue_is_compressed_i, issue_ex_valid_i,
  input  logic                        issue_ack_o, stall_issue_o,
  // scoreboard, commit and readiness
  input  xlen_t                       rs1_fwd_i, rs2_fwd_i,
  input  logic                        rs1_fwd_valid_i, rs2_fwd_valid_i,
  input  clobber_table_t              rd_clobber_i,
  input  commit_addr_t                commit_waddr_i,
  input  commit_data_t                commit_wdata_i,
  input  logic [`ISSUE_NR_COMMIT-1:0] commit_we_i,
  input  logic                        flu_ready_i, lsu_ready_i,
  // registered side toward execute
  input  xlen_t                       operand_a_o, operand_b_o, imm_o, pc_o,
  input  fu_t                         fu_o,
  input  fu_op_t                      op_o,
  input  trans_id_t                   trans_id_o,
  input  logic                        is_compressed_o,
  input  logic                        alu_valid_o, branch_valid_o, lsu_valid_o,
  input  logic                        mult_valid_o, csr_valid_o,
  output int                          err_count_o,
  output int                          check_count_o
);

  timeunit 1ns;
  timeprecision 100ps;

  // architectural state as the testbench believes it
  xlen_t     model_rf [`ISSUE_NR_REGS];
  // what the ID/EX register must hold after the next edge
  xlen_t     exp_a, exp_b, exp_imm, exp_pc;
  fu_t       exp_fu;
  fu_op_t    exp_op;
  trans_id_t exp_tid;
  logic      exp_c;
  // alu, branch, lsu, mult, csr from msb down
  logic [4:0] exp_valid;
  logic       have_exp;

  task automatic check_field(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    check_count_o++;
    if (got !== exp) begin
      err_count_o++;
      $display("MISMATCH at %0d ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // ----------------------------------------
  // hazard rules and next-cycle prediction
  // ----------------------------------------
  task automatic predict();
    fu_t  own1;
    fu_t  own2;
    logic fwd1, fwd2;
    logic stall1, stall2, stall;
    logic busy, rd_free, ack;
    own1 = rd_clobber_i[issue_rs1_i];
    own2 = rd_clobber_i[issue_rs2_i];
    // a pending csr result is never forwardable
    fwd1 = rs1_fwd_valid_i && (own1 != CSR);
    fwd2 = rs2_fwd_valid_i && (own2 != CSR);
    stall1 = !issue_use_zimm_i && (own1 != NONE) && !fwd1;
    stall2 = (own2 != NONE) && !fwd2;
    fwd1 = !issue_use_zimm_i && (own1 != NONE) && fwd1;
    fwd2 = (own2 != NONE) && fwd2;
    stall = stall_i || stall1 || stall2;
    busy = 1'b0;
    if (issue_fu_i inside {ALU, CTRL_FLOW, CSR, MULT}) begin
      busy = !flu_ready_i;
    end else if (issue_fu_i inside {LOAD, STORE}) begin
      busy = !lsu_ready_i;
    end
    // a same-cycle commit of rd releases a pending WAW
    rd_free = (rd_clobber_i[issue_rd_i] == NONE);
    for (int p = 0; p < `ISSUE_NR_COMMIT; p++) begin
      if (commit_we_i[p] && (commit_waddr_i[p] == issue_rd_i)) begin
        rd_free = 1'b1;
      end
    end
    ack = issue_valid_i &&
          ((!stall && !busy && rd_free) || issue_ex_valid_i || (issue_fu_i == NONE));
    // mult valid of the previous prediction is the one on the output now
    if (exp_valid[1] && (issue_fu_i inside {ALU, CTRL_FLOW, CSR})) begin
      ack = 1'b0;
    end
    check_field("issue_ack_o", 32'(issue_ack_o), 32'(ack));
    check_field("stall_issue_o", 32'(stall_issue_o), 32'(stall));

    if (issue_use_zimm_i) begin
      exp_a = 32'(issue_rs1_i);
    end else if (issue_use_pc_i) begin
      exp_a = issue_pc_i;
    end else if (fwd1) begin
      exp_a = rs1_fwd_i;
    end else begin
      exp_a = model_rf[issue_rs1_i];
    end
    if (issue_use_imm_i && !(issue_fu_i inside {STORE, CTRL_FLOW})) begin
      exp_b = issue_imm_i;
    end else if (fwd2) begin
      exp_b = rs2_fwd_i;
    end else begin
      exp_b = model_rf[issue_rs2_i];
    end
    exp_imm = issue_imm_i;
    exp_pc  = issue_pc_i;
    exp_fu  = issue_fu_i;
    exp_op  = issue_op_i;
    exp_tid = issue_trans_id_i;
    exp_c   = issue_is_compressed_i;

    exp_valid = '0;
    if (ack && !issue_ex_valid_i && !flush_i) begin
      case (issue_fu_i)
        ALU:         exp_valid[4] = 1'b1;
        CTRL_FLOW:   exp_valid[3] = 1'b1;
        LOAD, STORE: exp_valid[2] = 1'b1;
        MULT:        exp_valid[1] = 1'b1;
        CSR:         exp_valid[0] = 1'b1;
        default:     exp_valid    = '0;
      endcase
    end
    have_exp = 1'b1;
  endtask

  // ----------------------------------------
  // sampling at the falling edge
  // ----------------------------------------
  // inputs changed at the rising edge and have settled by now
  always @(negedge clk_i) begin
    if (!rst_ni) begin
      for (int i = 0; i < `ISSUE_NR_REGS; i++) begin
        model_rf[i] = '0;
      end
      exp_valid     = '0;
      have_exp      = 1'b0;
      err_count_o   = 0;
      check_count_o = 0;
    end else begin
      if (have_exp) begin
        check_field("operand_a_o", operand_a_o, exp_a);
        check_field("operand_b_o", operand_b_o, exp_b);
        check_field("imm_o", imm_o, exp_imm);
        check_field("pc_o", pc_o, exp_pc);
        check_field("fu_o", 32'(fu_o), 32'(exp_fu));
        check_field("op_o", 32'(op_o), 32'(exp_op));
        check_field("trans_id_o", 32'(trans_id_o), 32'(exp_tid));
        check_field("is_compressed_o", 32'(is_compressed_o), 32'(exp_c));
        check_field("unit valids",
                    32'({alu_valid_o, branch_valid_o, lsu_valid_o, mult_valid_o, csr_valid_o}),
                    32'(exp_valid));
      end
      predict();
      // commits land at the coming edge and the higher port goes last
      for (int p = 0; p < `ISSUE_NR_COMMIT; p++) begin
        if (commit_we_i[p] && (commit_waddr_i[p] != '0)) begin
          model_rf[commit_waddr_i[p]] = commit_wdata_i[p];
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/issue_stage.sv ====
`default_nettype none

`include "issue_settings.svh"

module issue_stage
  import fu_pkg::*;
  import reg_pkg::*;
(
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        flush_i,
  input  logic                        stall_i,
  // scoreboard entry
  input  logic                        issue_valid_i,
  input  fu_t                         issue_fu_i,
  input  fu_op_t                      issue_op_i,
  input  reg_addr_t                   issue_rs1_i,
  input  reg_addr_t                   issue_rs2_i,
  input  reg_addr_t                   issue_rd_i,
  input  xlen_t                       issue_imm_i,
  input  xlen_t                       issue_pc_i,
  input  trans_id_t                   issue_trans_id_i,
  input  logic                        issue_use_imm_i,
  input  logic                        issue_use_pc_i,
  input  logic                        issue_use_zimm_i,
  input  logic                        issue_is_compressed_i,
  input  logic                        issue_ex_valid_i,
  output logic                        issue_ack_o,
  output logic                        stall_issue_o,
  // scoreboard forwarding
  input  xlen_t                       rs1_fwd_i,
  input  logic                        rs1_fwd_valid_i,
  input  xlen_t                       rs2_fwd_i,
  input  logic                        rs2_fwd_valid_i,
  input  clobber_table_t              rd_clobber_i,
  // commit
  input  commit_addr_t                commit_waddr_i,
  input  commit_data_t                commit_wdata_i,
  input  logic [`ISSUE_NR_COMMIT-1:0] commit_we_i,
  // execute readiness
  input  logic                        flu_ready_i,
  input  logic                        lsu_ready_i,
  // toward execute
  output xlen_t                       operand_a_o,
  output xlen_t                       operand_b_o,
  output xlen_t                       imm_o,
  output fu_t                         fu_o,
  output fu_op_t                      op_o,
  output trans_id_t                   trans_id_o,
  output xlen_t                       pc_o,
  output logic                        is_compressed_o,
  output logic                        alu_valid_o,
  output logic                        branch_valid_o,
  output logic                        lsu_valid_o,
  output logic                        mult_valid_o,
  output logic                        csr_valid_o
);

  xlen_t rf_rs1;
  xlen_t rf_rs2;
  xlen_t operand_a;
  xlen_t operand_b;
  logic  fwd_rs1;
  logic  fwd_rs2;

  // ----------------------------------------
  // integer register file
  // ----------------------------------------
  gpr_regfile gpr_regfile_inst (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .raddr_a_i (issue_rs1_i),
    .raddr_b_i (issue_rs2_i),
    .rdata_a_o (rf_rs1),
    .rdata_b_o (rf_rs2),
    .waddr_i   (commit_waddr_i),
    .wdata_i   (commit_wdata_i),
    .we_i      (commit_we_i)
  );

  // hazards, forwarding and acknowledge
  issue_hazard issue_hazard_inst (
    .issue_valid_i    (issue_valid_i),
    .issue_fu_i       (issue_fu_i),
    .issue_rs1_i      (issue_rs1_i),
    .issue_rs2_i      (issue_rs2_i),
    .issue_rd_i       (issue_rd_i),
    .issue_use_zimm_i (issue_use_zimm_i),
    .issue_ex_valid_i (issue_ex_valid_i),
    .rs1_fwd_valid_i  (rs1_fwd_valid_i),
    .rs2_fwd_valid_i  (rs2_fwd_valid_i),
    .rd_clobber_i     (rd_clobber_i),
    .commit_waddr_i   (commit_waddr_i),
    .commit_we_i      (commit_we_i),
    .stall_i          (stall_i),
    .flu_ready_i      (flu_ready_i),
    .lsu_ready_i      (lsu_ready_i),
    // registered multiply valid fed back
    .mult_pending_i   (mult_valid_o),
    .fwd_rs1_o        (fwd_rs1),
    .fwd_rs2_o        (fwd_rs2),
    .stall_o          (stall_issue_o),
    .issue_ack_o      (issue_ack_o)
  );

  // operand selection
  operand_mux operand_mux_inst (
    .issue_fu_i       (issue_fu_i),
    .issue_rs1_i      (issue_rs1_i),
    .issue_imm_i      (issue_imm_i),
    .issue_pc_i       (issue_pc_i),
    .issue_use_imm_i  (issue_use_imm_i),
    .issue_use_pc_i   (issue_use_pc_i),
    .issue_use_zimm_i (issue_use_zimm_i),
    .fwd_rs1_i        (fwd_rs1),
    .fwd_rs2_i        (fwd_rs2),
    .rs1_fwd_i        (rs1_fwd_i),
    .rs2_fwd_i        (rs2_fwd_i),
    .rf_rs1_i         (rf_rs1),
    .rf_rs2_i         (rf_rs2),
    .operand_a_o      (operand_a),
    .operand_b_o      (operand_b)
  );

  // ----------------------------------------
  // ID/EX register
  // ----------------------------------------
  ex_dispatch_reg ex_dispatch_reg_inst (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .flush_i               (flush_i),
    .issue_valid_i         (issue_valid_i),
    .issue_ack_i           (issue_ack_o),
    .issue_ex_valid_i      (issue_ex_valid_i),
    .issue_fu_i            (issue_fu_i),
    .issue_op_i            (issue_op_i),
    .issue_imm_i           (issue_imm_i),
    .issue_pc_i            (issue_pc_i),
    .issue_trans_id_i      (issue_trans_id_i),
    .issue_is_compressed_i (issue_is_compressed_i),
    .operand_a_i           (operand_a),
    .operand_b_i           (operand_b),
    .operand_a_o           (operand_a_o),
    .operand_b_o           (operand_b_o),
    .imm_o                 (imm_o),
    .fu_o                  (fu_o),
    .op_o                  (op_o),
    .trans_id_o            (trans_id_o),
    .pc_o                  (pc_o),
    .is_compressed_o       (is_compressed_o),
    .alu_valid_o           (alu_valid_o),
    .branch_valid_o        (branch_valid_o),
    .lsu_valid_o           (lsu_valid_o),
    .mult_valid_o          (mult_valid_o),
    .csr_valid_o           (csr_valid_o)
  );

endmodule

`default_nettype wire

// ==== src/ex_dispatch_reg.sv ====
`default_nettype none

`include "issue_settings.svh"

module ex_dispatch_reg
  import fu_pkg::*;
  import reg_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      flush_i,
  // handshake of the current entry
  input  logic      issue_valid_i,
  input  logic      issue_ack_i,
  input  logic      issue_ex_valid_i,
  // entry payload
  input  fu_t       issue_fu_i,
  input  fu_op_t    issue_op_i,
  input  xlen_t     issue_imm_i,
  input  xlen_t     issue_pc_i,
  input  trans_id_t issue_trans_id_i,
  input  logic      issue_is_compressed_i,
  input  xlen_t     operand_a_i,
  input  xlen_t     operand_b_i,
  // toward execute
  output xlen_t     operand_a_o,
  output xlen_t     operand_b_o,
  output xlen_t     imm_o,
  output fu_t       fu_o,
  output fu_op_t    op_o,
  output trans_id_t trans_id_o,
  output xlen_t     pc_o,
  output logic      is_compressed_o,
  output logic      alu_valid_o,
  output logic      branch_valid_o,
  output logic      lsu_valid_o,
  output logic      mult_valid_o,
  output logic      csr_valid_o
);

  logic dispatch;

  // accepted and not faulting, so a unit must start
  assign dispatch = issue_valid_i & issue_ack_i & ~issue_ex_valid_i;

  // ----------------------------------------
  // payload, loads every cycle
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    operand_a_o     <= operand_a_i;
    operand_b_o     <= operand_b_i;
    imm_o           <= issue_imm_i;
    trans_id_o      <= issue_trans_id_i;
    pc_o            <= issue_pc_i;
    is_compressed_o <= issue_is_compressed_i;
  end

  // unit and op tags come out of reset in a known state
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fu_o <= NONE;
      op_o <= ADD;
    end else begin
      fu_o <= issue_fu_i;
      op_o <= issue_op_i;
    end
  end

  // ----------------------------------------
  // per-unit valids
  // ----------------------------------------
  // one-hot decode of the fu, flush wins over a fresh issue
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      alu_valid_o    <= 1'b0;
      branch_valid_o <= 1'b0;
      lsu_valid_o    <= 1'b0;
      mult_valid_o   <= 1'b0;
      csr_valid_o    <= 1'b0;
    end else begin
      alu_valid_o    <= dispatch && !flush_i && (issue_fu_i == ALU);
      branch_valid_o <= dispatch && !flush_i && (issue_fu_i == CTRL_FLOW);
      lsu_valid_o    <= dispatch && !flush_i && (issue_fu_i inside {LOAD, STORE});
      mult_valid_o   <= dispatch && !flush_i && (issue_fu_i == MULT);
      csr_valid_o    <= dispatch && !flush_i && (issue_fu_i == CSR);
    end
  end

endmodule

`default_nettype wire

// ==== src/operand_mux.sv ====
`default_nettype none

`include "issue_settings.svh"

module operand_mux
  import fu_pkg::*;
  import reg_pkg::*;
(
  input  fu_t       issue_fu_i,
  input  reg_addr_t issue_rs1_i,
  input  xlen_t     issue_imm_i,
  input  xlen_t     issue_pc_i,
  input  logic      issue_use_imm_i,
  input  logic      issue_use_pc_i,
  input  logic      issue_use_zimm_i,
  // forward selects from hazard logic
  input  logic      fwd_rs1_i,
  input  logic      fwd_rs2_i,
  // forwarded scoreboard results
  input  xlen_t     rs1_fwd_i,
  input  xlen_t     rs2_fwd_i,
  // register file read data
  input  xlen_t     rf_rs1_i,
  input  xlen_t     rf_rs2_i,
  output xlen_t     operand_a_o,
  output xlen_t     operand_b_o
);

  xlen_t zimm;

  // csr immediate sits in the rs1 field, zero extended
  assign zimm = {{(`ISSUE_XLEN - `ISSUE_REG_ADDR_BITS){1'b0}}, issue_rs1_i};

  // ----------------------------------------
  // operand a
  // ----------------------------------------
  // zimm first, then pc, then forwarded, regfile last
  always_comb begin
    if (issue_use_zimm_i) begin
      operand_a_o = zimm;
    end else if (issue_use_pc_i) begin
      operand_a_o = issue_pc_i;
    end else if (fwd_rs1_i) begin
      operand_a_o = rs1_fwd_i;
    end else begin
      operand_a_o = rf_rs1_i;
    end
  end

  // ----------------------------------------
  // operand b
  // ----------------------------------------
  // stores and branches keep rs2 here, their imm goes out separately
  always_comb begin
    if (issue_use_imm_i && (issue_fu_i != STORE) && (issue_fu_i != CTRL_FLOW)) begin
      operand_b_o = issue_imm_i;
    end else if (fwd_rs2_i) begin
      operand_b_o = rs2_fwd_i;
    end else begin
      operand_b_o = rf_rs2_i;
    end
  end

endmodule

`default_nettype wire

// ==== src/issue_hazard.sv ====
`default_nettype none

`include "issue_settings.svh"

module issue_hazard
  import fu_pkg::*;
  import reg_pkg::*;
(
  // current scoreboard entry
  input  logic                        issue_valid_i,
  input  fu_t                         issue_fu_i,
  input  reg_addr_t                   issue_rs1_i,
  input  reg_addr_t                   issue_rs2_i,
  input  reg_addr_t                   issue_rd_i,
  input  logic                        issue_use_zimm_i,
  input  logic                        issue_ex_valid_i,
  // scoreboard forwarding state
  input  logic                        rs1_fwd_valid_i,
  input  logic                        rs2_fwd_valid_i,
  input  clobber_table_t              rd_clobber_i,
  // commit writes in this cycle
  input  commit_addr_t                commit_waddr_i,
  input  logic [`ISSUE_NR_COMMIT-1:0] commit_we_i,
  // external stall and unit readiness
  input  logic                        stall_i,
  input  logic                        flu_ready_i,
  input  logic                        lsu_ready_i,
  input  logic                        mult_pending_i,
  output logic                        fwd_rs1_o,
  output logic                        fwd_rs2_o,
  output logic                        stall_o,
  output logic                        issue_ack_o
);

  fu_t  rs1_owner;
  fu_t  rs2_owner;
  logic rs1_stall;
  logic rs2_stall;
  logic fu_busy;
  logic rd_released;

  // ----------------------------------------
  // RAW check and forwarding
  // ----------------------------------------
  assign rs1_owner = rd_clobber_i[issue_rs1_i];
  assign rs2_owner = rd_clobber_i[issue_rs2_i];

  // csr results are never forwarded, they come through the regfile
  // zimm carries an immediate in the rs1 field, no dependency there
  always_comb begin
    fwd_rs1_o = 1'b0;
    fwd_rs2_o = 1'b0;
    rs1_stall = 1'b0;
    rs2_stall = 1'b0;
    if (!issue_use_zimm_i && (rs1_owner != NONE)) begin
      if (rs1_fwd_valid_i && (rs1_owner != CSR)) begin
        fwd_rs1_o = 1'b1;
      end else begin
        rs1_stall = 1'b1;
      end
    end
    if (rs2_owner != NONE) begin
      if (rs2_fwd_valid_i && (rs2_owner != CSR)) begin
        fwd_rs2_o = 1'b1;
      end else begin
        rs2_stall = 1'b1;
      end
    end
  end

  assign stall_o = stall_i | rs1_stall | rs2_stall;

  // ----------------------------------------
  // unit busy
  // ----------------------------------------
  always_comb begin
    unique case (issue_fu_i)
      ALU, CTRL_FLOW, CSR, MULT: fu_busy = ~flu_ready_i;
      LOAD, STORE:               fu_busy = ~lsu_ready_i;
      default:                   fu_busy = 1'b0;
    endcase
  end

  // ----------------------------------------
  // WAW check and acknowledge
  // ----------------------------------------
  // a commit writing rd this cycle frees the destination
  always_comb begin
    rd_released = 1'b0;
    for (int unsigned i = 0; i < `ISSUE_NR_COMMIT; i++) begin
      if (commit_we_i[i] && (commit_waddr_i[i] == issue_rd_i)) begin
        rd_released = 1'b1;
      end
    end
  end

  always_comb begin
    issue_ack_o = 1'b0;
    if (issue_valid_i) begin
      if (!stall_o && !fu_busy && ((rd_clobber_i[issue_rd_i] == NONE) || rd_released)) begin
        issue_ack_o = 1'b1;
      end
      // faulting entries and unit-less entries bypass execute
      if (issue_ex_valid_i || (issue_fu_i == NONE)) begin
        issue_ack_o = 1'b1;
      end
    end
    // multiply result owns the fixed-latency writeback next cycle
    if (mult_pending_i && (issue_fu_i inside {ALU, CTRL_FLOW, CSR})) begin
      issue_ack_o = 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== src/gpr_regfile.sv ====
`default_nettype none

`include "issue_settings.svh"

module gpr_regfile
  import reg_pkg::*;
(
  input  logic                        clk_i,
  input  logic                        rst_ni,
  // operand read ports
  input  reg_addr_t                   raddr_a_i,
  input  reg_addr_t                   raddr_b_i,
  output xlen_t                       rdata_a_o,
  output xlen_t                       rdata_b_o,
  // commit write ports
  input  commit_addr_t                waddr_i,
  input  commit_data_t                wdata_i,
  input  logic [`ISSUE_NR_COMMIT-1:0] we_i
);

  // register storage, x0 slot included but never written
  xlen_t [`ISSUE_NR_REGS-1:0] mem_q;

  // ----------------------------------------
  // write side
  // ----------------------------------------
  // later ports overwrite earlier ones, so the highest port wins
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mem_q <= '0;
    end else begin
      for (int unsigned i = 0; i < `ISSUE_NR_COMMIT; i++) begin
        // x0 stays hard zero
        if (we_i[i] && (waddr_i[i] != '0)) begin
          mem_q[waddr_i[i]] <= wdata_i[i];
        end
      end
    end
  end

  // ----------------------------------------
  // read side
  // ----------------------------------------
  // combinational, returns the value before a same-cycle write
  assign rdata_a_o = mem_q[raddr_a_i];
  assign rdata_b_o = mem_q[raddr_b_i];

endmodule

`default_nettype wire

// ==== src/reg_pkg.sv ====
`default_nettype none

`include "issue_settings.svh"

package reg_pkg;

  // one integer data word
  typedef logic [`ISSUE_XLEN-1:0] xlen_t;

  // architectural register index
  typedef logic [`ISSUE_REG_ADDR_BITS-1:0] reg_addr_t;

  // scoreboard slot tag
  typedef logic [`ISSUE_TRANS_ID_BITS-1:0] trans_id_t;

  // commit side, one lane per commit port
  typedef reg_addr_t [`ISSUE_NR_COMMIT-1:0] commit_addr_t;
  typedef xlen_t [`ISSUE_NR_COMMIT-1:0] commit_data_t;

endpackage

`default_nettype wire

// ==== src/fu_pkg.sv ====
`default_nettype none

`include "issue_settings.svh"

package fu_pkg;

  // functional unit that consumes an issued entry
  typedef enum logic [2:0] {
    NONE,
    ALU,
    CTRL_FLOW,
    LOAD,
    STORE,
    MULT,
    CSR
  } fu_t;

  // operation code, passed to execute untouched
  typedef enum logic [3:0] {
    ADD, SUB, XORL, ORL,
    ANDL, SLL, SRL, SRA,
    SLTS, SLTU, EQ, NE,
    LW, SW, MUL, CSR_RW
  } fu_op_t;

  // pending writer of each register, NONE when nothing is in flight
  typedef fu_t [`ISSUE_NR_REGS-1:0] clobber_table_t;

endpackage

`default_nettype wire

// ==== src/issue_settings.svh ====
`ifndef ISSUE_SETTINGS_SVH
`define ISSUE_SETTINGS_SVH

// ----------------------------------------
// datapath widths
// ----------------------------------------

// integer data word
`define ISSUE_XLEN 32

// architectural integer registers, x0 included
`define ISSUE_NR_REGS 32
`define ISSUE_REG_ADDR_BITS 5

// ----------------------------------------
// commit and scoreboard sizing
// ----------------------------------------

// commit write ports into the register file
`define ISSUE_NR_COMMIT 2
// scoreboard tag carried with each entry
`define ISSUE_TRANS_ID_BITS 3

`endif
